// File: logic/axis_window_calc.sv
module axis_window_calc (
  input  logic                SYS_CLK,
  input  logic                reset_i,
  input  scaler_pkg::size_t   src_i,
  input  scaler_pkg::size_t   offset_i,
  input  scaler_pkg::size_t   active_i,
  input  scaler_pkg::size_t   out_size_i,
  input  scaler_pkg::factor_t factor_i,
  input  logic                publish_i,
  output scaler_pkg::size_t   first_o,
  output scaler_pkg::size_t   needed_o,
  output scaler_pkg::size_t   full_o,
  output scaler_pkg::size_t   out_o,
  output scaler_pkg::factor_t factor_o
);
  import scaler_pkg::*;

  logic [FACTOR_W+SIZE_W-1:0]                 span_q;   // factor * src.
  logic [FACTOR_W+2*SIZE_W-1:0]               reach_q;  // factor * src * active.
  logic [FACTOR_W+2*SIZE_W-1:0]               rounded;
  logic [FACTOR_W+2*SIZE_W-RECIP_ONE_EXP-1:0] raw_need;
  size_t                                      needed_d;
  size_t                                      needed_q;
  size_t                                      first_q;

  // round to nearest, then clamp to what the source holds.
  always_comb begin
    rounded  = reach_q + (RECIP_ONE >> 1);
    raw_need = rounded[FACTOR_W+2*SIZE_W-1:RECIP_ONE_EXP];
    if (raw_need < src_i) begin
      needed_d = size_t'(raw_need);
    end else begin
      needed_d = src_i;
    end
  end

  always_ff @(posedge SYS_CLK) begin
    span_q   <= factor_i * src_i;
    reach_q  <= span_q * active_i;
    needed_q <= needed_d;
    first_q  <= offset_i + ((src_i - needed_d) >> 1);  // centred crop.
  end

  always_ff @(posedge SYS_CLK) begin
    if (reset_i) begin
      first_o  <= '0;
      needed_o <= '0;
      full_o   <= '0;
      out_o    <= '0;
      factor_o <= '0;
    end else if (publish_i) begin
      first_o  <= first_q;
      needed_o <= needed_q;
      full_o   <= src_i;
      out_o    <= out_size_i;
      factor_o <= factor_i;
    end
  end

endmodule

// File: logic/div_if.sv
interface div_if;
  import scaler_pkg::*;

  logic    cmd;       // one-cycle start pulse.
  size_t   divisor;
  factor_t quotient;  // valid from done until the next cmd.
  logic    busy;
  logic    done;

  modport controller (
    output cmd,
    output divisor,
    input  busy,
    input  done
  );

  modport divider (
    input  cmd,
    input  divisor,
    output quotient,
    output busy,
    output done
  );

endinterface

// File: logic/scaler_cfg_ctrl.sv
module scaler_cfg_ctrl (
  input  logic               SYS_CLK,
  input  logic               reset_i,
  input  logic               pal_i,
  input  logic               boxed_i,
  input  scaler_pkg::vmode_t vmode_i,
  input  scaler_pkg::scale_t vscale_i,
  input  scaler_pkg::scale_t hscale_i,
  output logic               cap_pal_o,
  output logic               cap_boxed_o,
  output scaler_pkg::vmode_t cap_vmode_o,
  output scaler_pkg::scale_t cap_vscale_o,
  output scaler_pkg::scale_t cap_hscale_o,
  input  scaler_pkg::size_t  vout_i,
  input  scaler_pkg::size_t  hout_i,
  div_if.controller          vdiv_port,
  div_if.controller          hdiv_port,
  output logic               publish_o
);
  import scaler_pkg::*;

  cfg_state_t              state_q;
  logic                    cap_valid_q;  // low after reset forces one run.
  logic                    cmd_q;
  logic                    v_seen_q;
  logic                    h_seen_q;
  logic [SETTLE_CNT_W-1:0] settle_cnt_q;
  logic                    changed;
  logic                    divs_idle;
  logic                    v_done;
  logic                    h_done;

  assign changed = !cap_valid_q || (pal_i != cap_pal_o) || (boxed_i != cap_boxed_o) ||
                   (vmode_i != cap_vmode_o) || (vscale_i != cap_vscale_o) ||
                   (hscale_i != cap_hscale_o);

  assign divs_idle = !vdiv_port.busy && !hdiv_port.busy;
  assign v_done    = v_seen_q || vdiv_port.done;
  assign h_done    = h_seen_q || hdiv_port.done;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // calculation FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge SYS_CLK) begin
    if (reset_i) begin
      state_q      <= IDLE;
      cap_valid_q  <= 1'b0;
      cap_pal_o    <= 1'b0;
      cap_boxed_o  <= 1'b0;
      cap_vmode_o  <= '0;
      cap_vscale_o <= '0;
      cap_hscale_o <= '0;
      cmd_q        <= 1'b0;
      v_seen_q     <= 1'b0;
      h_seen_q     <= 1'b0;
      settle_cnt_q <= '0;
    end else begin
      cmd_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (changed && divs_idle) begin
            cap_valid_q  <= 1'b1;
            cap_pal_o    <= pal_i;
            cap_boxed_o  <= boxed_i;
            cap_vmode_o  <= vmode_i;
            cap_vscale_o <= vscale_i;
            cap_hscale_o <= hscale_i;
            cmd_q        <= 1'b1;  // divisors settle from the captured values first.
            state_q      <= DIVIDE;
          end
        end
        DIVIDE: begin
          v_seen_q <= v_done;
          h_seen_q <= h_done;
          if (v_done && h_done) begin
            v_seen_q     <= 1'b0;
            h_seen_q     <= 1'b0;
            settle_cnt_q <= SETTLE_CNT_W'(SETTLE_CYCLES - 1);
            state_q      <= SETTLE;
          end
        end
        SETTLE: begin
          if (settle_cnt_q == '0) begin
            state_q <= PUBLISH;
          end else begin
            settle_cnt_q <= settle_cnt_q - 1'b1;
          end
        end
        default: state_q <= IDLE;  // PUBLISH lasts one cycle.
      endcase
    end
  end

  assign vdiv_port.cmd     = cmd_q;
  assign hdiv_port.cmd     = cmd_q;
  assign vdiv_port.divisor = vout_i;
  assign hdiv_port.divisor = hout_i;

  assign publish_o = (state_q == PUBLISH);

endmodule

// File: logic/scaler_cfggen_top.sv
module scaler_cfggen_top (
  input  logic                SYS_CLK,
  input  logic                reset_i,
  input  logic                palmode_i,
  input  logic                palmode_boxed_i,
  input  scaler_pkg::vmode_t  video_mode_i,
  input  scaler_pkg::scale_t  vscale_factor_i,
  input  scaler_pkg::scale_t  hscale_factor_i,
  output scaler_pkg::size_t   vpos_first_o,
  output scaler_pkg::size_t   vlines_needed_o,
  output scaler_pkg::size_t   vlines_full_o,
  output scaler_pkg::size_t   vlines_out_o,
  output scaler_pkg::factor_t v_interp_factor_o,
  output scaler_pkg::size_t   hpos_first_o,
  output scaler_pkg::size_t   hpixels_needed_o,
  output scaler_pkg::size_t   hpixels_full_o,
  output scaler_pkg::size_t   hpixels_out_o,
  output scaler_pkg::factor_t h_interp_factor_o,
  output logic                cfg_update_o
);
  import scaler_pkg::*;

  logic   cap_pal;
  logic   cap_boxed;
  vmode_t cap_vmode;
  scale_t cap_vscale;
  scale_t cap_hscale;
  size_t  vsrc;
  size_t  hsrc;
  size_t  voffset;
  size_t  vactive;
  size_t  hactive;
  size_t  vout;
  size_t  hout;
  logic   publish;

  div_if vdiv_bus ();
  div_if hdiv_bus ();

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control and sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  scaler_cfg_ctrl ctrl_u (
    .SYS_CLK     (SYS_CLK),
    .reset_i     (reset_i),
    .pal_i       (palmode_i),
    .boxed_i     (palmode_boxed_i),
    .vmode_i     (video_mode_i),
    .vscale_i    (vscale_factor_i),
    .hscale_i    (hscale_factor_i),
    .cap_pal_o   (cap_pal),
    .cap_boxed_o (cap_boxed),
    .cap_vmode_o (cap_vmode),
    .cap_vscale_o(cap_vscale),
    .cap_hscale_o(cap_hscale),
    .vout_i      (vout),
    .hout_i      (hout),
    .vdiv_port   (vdiv_bus),
    .hdiv_port   (hdiv_bus),
    .publish_o   (publish)
  );

  target_size_gen size_u (
    .pal_i    (cap_pal),
    .boxed_i  (cap_boxed),
    .vmode_i  (cap_vmode),
    .vscale_i (cap_vscale),
    .hscale_i (cap_hscale),
    .vsrc_o   (vsrc),
    .hsrc_o   (hsrc),
    .voffset_o(voffset),
    .vactive_o(vactive),
    .hactive_o(hactive),
    .vout_o   (vout),
    .hout_o   (hout)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per-axis datapath
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  serial_divide v_div_u (
    .SYS_CLK (SYS_CLK),
    .reset_i (reset_i),
    .div_port(vdiv_bus)
  );

  serial_divide h_div_u (
    .SYS_CLK (SYS_CLK),
    .reset_i (reset_i),
    .div_port(hdiv_bus)
  );

  axis_window_calc v_win_u (
    .SYS_CLK   (SYS_CLK),
    .reset_i   (reset_i),
    .src_i     (vsrc),
    .offset_i  (voffset),
    .active_i  (vactive),
    .out_size_i(vout),
    .factor_i  (vdiv_bus.quotient),
    .publish_i (publish),
    .first_o   (vpos_first_o),
    .needed_o  (vlines_needed_o),
    .full_o    (vlines_full_o),
    .out_o     (vlines_out_o),
    .factor_o  (v_interp_factor_o)
  );

  axis_window_calc h_win_u (
    .SYS_CLK   (SYS_CLK),
    .reset_i   (reset_i),
    .src_i     (hsrc),
    .offset_i  ('0),  // no horizontal boxing.
    .active_i  (hactive),
    .out_size_i(hout),
    .factor_i  (hdiv_bus.quotient),
    .publish_i (publish),
    .first_o   (hpos_first_o),
    .needed_o  (hpixels_needed_o),
    .full_o    (hpixels_full_o),
    .out_o     (hpixels_out_o),
    .factor_o  (h_interp_factor_o)
  );

  // new outputs show from the cycle after the pulse.
  assign cfg_update_o = publish;

endmodule

// File: logic/scaler_pkg.sv
package scaler_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int SIZE_W   = 12;
  localparam int FACTOR_W = 18;
  localparam int SCALE_W  = 5;
  localparam int VMODE_W  = 2;

  typedef logic [SIZE_W-1:0]   size_t;    // line or pixel count.
  typedef logic [FACTOR_W-1:0] factor_t;  // interpolation step, 0.17 fixed point.
  typedef logic [SCALE_W-1:0]  scale_t;
  typedef logic [VMODE_W-1:0]  vmode_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // source geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam size_t SRC_LINES_NTSC = 12'd240;
  localparam size_t SRC_LINES_PAL  = 12'd288;
  localparam size_t SRC_PIXELS     = 12'd320;
  localparam size_t BOXED_OFFSET   = 12'd24;   // lines skipped for boxed PAL.

  // output size is src * (scale + SCALE_BASE) >> SCALE_FRAC_BITS.
  localparam int SCALE_BASE      = 4;
  localparam int SCALE_FRAC_BITS = 2;

  // output mode table, indexed by the video mode code.
  localparam size_t MODE_LINES [4] = '{12'd480, 12'd720, 12'd960, 12'd1080};
  localparam size_t MODE_PIXELS [4] = '{12'd640, 12'd1280, 12'd1280, 12'd1920};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reciprocal divider
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int      RECIP_ONE_EXP = 17;
  localparam factor_t RECIP_ONE     = factor_t'(1) << RECIP_ONE_EXP;
  localparam int      DIV_STEPS     = RECIP_ONE_EXP + 1;  // one quotient bit per step.
  localparam int      DIV_CNT_W     = $clog2(DIV_STEPS);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int SETTLE_CYCLES = 4;  // covers the three-stage window pipeline.
  localparam int SETTLE_CNT_W  = $clog2(SETTLE_CYCLES);

  typedef enum logic [1:0] {
    IDLE,
    DIVIDE,
    SETTLE,
    PUBLISH
  } cfg_state_t;

endpackage

// File: logic/serial_divide.sv
module serial_divide (
  input  logic   SYS_CLK,
  input  logic   reset_i,
  div_if.divider div_port
);
  import scaler_pkg::*;

  logic                 busy_q;
  logic                 done_q;
  logic [DIV_CNT_W-1:0] step_q;
  size_t                rem_q;
  factor_t              shreg_q;  // dividend bits leave at the top, quotient bits enter below.
  logic [SIZE_W:0]      trial;
  logic                 fits;
  logic                 start;

  assign start = div_port.cmd && !busy_q;

  // restoring step: bring down the next dividend bit and try the divisor.
  always_comb begin
    trial = {rem_q, shreg_q[FACTOR_W-1]};
    fits  = trial >= {1'b0, div_port.divisor};
  end

  always_ff @(posedge SYS_CLK) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start) begin
        busy_q <= 1'b1;
      end else if (busy_q && step_q == DIV_CNT_W'(DIV_STEPS - 1)) begin
        busy_q <= 1'b0;  // last bit lands together with done.
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge SYS_CLK) begin
    if (start) begin
      rem_q   <= '0;
      shreg_q <= RECIP_ONE;
      step_q  <= '0;
    end else if (busy_q) begin
      if (fits) begin
        rem_q <= size_t'(trial - {1'b0, div_port.divisor});
      end else begin
        rem_q <= size_t'(trial);
      end
      shreg_q <= {shreg_q[FACTOR_W-2:0], fits};
      step_q  <= step_q + 1'b1;
    end
  end

  assign div_port.quotient = shreg_q;  // holds after done.
  assign div_port.busy     = busy_q;
  assign div_port.done     = done_q;

endmodule

// File: logic/target_size_gen.sv
module target_size_gen (
  input  logic               pal_i,
  input  logic               boxed_i,
  input  scaler_pkg::vmode_t vmode_i,
  input  scaler_pkg::scale_t vscale_i,
  input  scaler_pkg::scale_t hscale_i,
  output scaler_pkg::size_t  vsrc_o,
  output scaler_pkg::size_t  hsrc_o,
  output scaler_pkg::size_t  voffset_o,
  output scaler_pkg::size_t  vactive_o,
  output scaler_pkg::size_t  hactive_o,
  output scaler_pkg::size_t  vout_o,
  output scaler_pkg::size_t  hout_o
);
  import scaler_pkg::*;

  logic pal_full;
  logic pal_boxed;

  // src * (scale + 4) / 4, shift and add over the multiplier bits.
  function automatic size_t scaled_size(input size_t src, input scale_t scale);
    logic [SCALE_W:0]        mult;
    logic [SIZE_W+SCALE_W:0] acc;
    mult = {1'b0, scale} + (SCALE_W + 1)'(SCALE_BASE);
    acc  = '0;
    for (int i = 0; i <= SCALE_W; i++) begin
      if (mult[i]) begin
        acc = acc + ((SIZE_W + SCALE_W + 1)'(src) << i);
      end
    end
    return size_t'(acc >> SCALE_FRAC_BITS);
  endfunction

  assign pal_full  = pal_i && !boxed_i;  // PAL in its own height.
  assign pal_boxed = pal_i && boxed_i;

  assign vsrc_o    = pal_full ? SRC_LINES_PAL : SRC_LINES_NTSC;
  assign hsrc_o    = SRC_PIXELS;
  assign voffset_o = pal_boxed ? BOXED_OFFSET : '0;

  assign vactive_o = MODE_LINES[vmode_i];
  assign hactive_o = MODE_PIXELS[vmode_i];

  assign vout_o = scaled_size(vsrc_o, vscale_i);
  assign hout_o = scaled_size(hsrc_o, hscale_i);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_scaler_cfggen -o tb_sim &&
  ./obj_dir/tb_sim | tee /dev/stderr | grep -q "TEST PASSED" &&
  echo "simulation ok" ||
  { echo "simulation failed"; exit 1; }

// File: sources.f
logic/scaler_pkg.sv
logic/div_if.sv
logic/serial_divide.sv
logic/target_size_gen.sv
logic/axis_window_calc.sv
logic/scaler_cfg_ctrl.sv
logic/scaler_cfggen_top.sv
test/tb_scaler_cfggen.sv

// File: test/tb_scaler_cfggen.sv
module tb_scaler_cfggen;
  import scaler_pkg::*;

  localparam int UPDATE_TIMEOUT = 200;
  localparam int QUIET_CYCLES   = 100;
  localparam int LINES_TBL [4]  = '{480, 720, 960, 1080};  // active lines per mode.
  localparam int PIXELS_TBL [4] = '{640, 1280, 1280, 1920};

  logic    SYS_CLK;
  logic    reset_i;
  logic    palmode_i;
  logic    palmode_boxed_i;
  vmode_t  video_mode_i;
  scale_t  vscale_factor_i;
  scale_t  hscale_factor_i;
  size_t   vpos_first_o;
  size_t   vlines_needed_o;
  size_t   vlines_full_o;
  size_t   vlines_out_o;
  factor_t v_interp_factor_o;
  size_t   hpos_first_o;
  size_t   hpixels_needed_o;
  size_t   hpixels_full_o;
  size_t   hpixels_out_o;
  factor_t h_interp_factor_o;
  logic    cfg_update_o;

  int      seed = 19868;
  int      err_cnt = 0;
  int      update_cnt = 0;
  int      test_cnt = 0;
  int      test_fail_cnt = 0;
  size_t   exp_vfirst, exp_vneed, exp_vfull, exp_vout;
  size_t   exp_hfirst, exp_hneed, exp_hfull, exp_hout;
  factor_t exp_vfac, exp_hfac;

  scaler_cfggen_top dut_i (.*);

  initial begin
    SYS_CLK = 1'b0;
    forever #5 SYS_CLK = ~SYS_CLK;
  end

  always @(posedge SYS_CLK) begin
    if (cfg_update_o) begin
      update_cnt <= update_cnt + 1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic void axis_model(input int src, input int offset, input int active,
                                     input int scale, output size_t first, output size_t need,
                                     output size_t out, output factor_t fac);
    int     out_n;
    int     fac_n;
    int     need_n;
    longint raw;
    out_n  = src * (scale + 4) / 4;
    fac_n  = (1 << 17) / out_n;
    raw    = (longint'(fac_n) * src * active + (longint'(1) << 16)) >> 17;
    need_n = (raw < longint'(src)) ? int'(raw) : src;  // never more than the source holds.
    first  = size_t'(offset + (src - need_n) / 2);
    need   = size_t'(need_n);
    out    = size_t'(out_n);
    fac    = factor_t'(fac_n);
  endfunction

  task automatic set_expected(input logic pal, input logic boxed, input int mode,
                              input int vs, input int hs);
    int vsrc;
    int voff;
    vsrc      = (pal && !boxed) ? 288 : 240;
    voff      = (pal && boxed) ? 24 : 0;
    exp_vfull = size_t'(vsrc);
    exp_hfull = size_t'(320);
    axis_model(vsrc, voff, LINES_TBL[mode], vs, exp_vfirst, exp_vneed, exp_vout, exp_vfac);
    axis_model(320, 0, PIXELS_TBL[mode], hs, exp_hfirst, exp_hneed, exp_hout, exp_hfac);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic report_mismatch(input string name, input int got, input int exp);
    err_cnt++;
    $display("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp);
  endtask

  // outputs load on the pulse edge, so they are compared one edge later.
  vfirst_chk: assert property (@(posedge SYS_CLK) disable iff (reset_i)
    cfg_update_o |=> vpos_first_o == exp_vfirst)
    else report_mismatch("vpos_first_o", int'(vpos_first_o), int'(exp_vfirst));
  vneed_chk: assert property (@(posedge SYS_CLK) disable iff (reset_i)
    cfg_update_o |=> vlines_needed_o == exp_vneed)
    else report_mismatch("vlines_needed_o", int'(vlines_needed_o), int'(exp_vneed));
  vfull_chk: assert property (@(posedge SYS_CLK) disable iff (reset_i)
    cfg_update_o |=> vlines_full_o == exp_vfull)
    else report_mismatch("vlines_full_o", int'(vlines_full_o), int'(exp_vfull));
  vout_chk: assert property (@(posedge SYS_CLK) disable iff (reset_i)
    cfg_update_o |=> vlines_out_o == exp_vout)
    else report_mismatch("vlines_out_o", int'(vlines_out_o), int'(exp_vout));
  vfac_chk: assert property (@(posedge SYS_CLK) disable iff (reset_i)
    cfg_update_o |=> v_interp_factor_o == exp_vfac)
    else report_mismatch("v_interp_factor_o", int'(v_interp_factor_o), int'(exp_vfac));
  hfirst_chk: assert property (@(posedge SYS_CLK) disable iff (reset_i)
    cfg_update_o |=> hpos_first_o == exp_hfirst)
    else report_mismatch("hpos_first_o", int'(hpos_first_o), int'(exp_hfirst));
  hneed_chk: assert property (@(posedge SYS_CLK) disable iff (reset_i)
    cfg_update_o |=> hpixels_needed_o == exp_hneed)
    else report_mismatch("hpixels_needed_o", int'(hpixels_needed_o), int'(exp_hneed));
  hfull_chk: assert property (@(posedge SYS_CLK) disable iff (reset_i)
    cfg_update_o |=> hpixels_full_o == exp_hfull)
    else report_mismatch("hpixels_full_o", int'(hpixels_full_o), int'(exp_hfull));
  hout_chk: assert property (@(posedge SYS_CLK) disable iff (reset_i)
    cfg_update_o |=> hpixels_out_o == exp_hout)
    else report_mismatch("hpixels_out_o", int'(hpixels_out_o), int'(exp_hout));
  hfac_chk: assert property (@(posedge SYS_CLK) disable iff (reset_i)
    cfg_update_o |=> h_interp_factor_o == exp_hfac)
    else report_mismatch("h_interp_factor_o", int'(h_interp_factor_o), int'(exp_hfac));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic drive_inputs(input logic pal, input logic boxed, input int mode,
                              input int vs, input int hs);
    @(negedge SYS_CLK);
    palmode_i       = pal;
    palmode_boxed_i = boxed;
    video_mode_i    = vmode_t'(mode);
    vscale_factor_i = scale_t'(vs);
    hscale_factor_i = scale_t'(hs);
  endtask

  task automatic wait_update();
    int start;
    int cycles;
    start  = update_cnt;
    cycles = 0;
    while (update_cnt == start && cycles < UPDATE_TIMEOUT) begin
      @(negedge SYS_CLK);
      cycles++;
    end
    if (update_cnt == start) begin
      err_cnt++;
      $display("no cfg_update_o within %0d cycles, t=%0t", UPDATE_TIMEOUT, $time);
    end else begin
      @(negedge SYS_CLK);  // checks have fired on the rising edge before this one.
    end
  endtask

  task automatic check_quiet();
    int start;
    start = update_cnt;
    repeat (QUIET_CYCLES) @(negedge SYS_CLK);
    if (update_cnt != start) begin
      err_cnt++;
      $display("%0d extra cfg_update_o pulses while inputs were held, t=%0t",
               update_cnt - start, $time);
    end
  endtask

  // unchanged settings start no calculation, so nothing to wait for.
  task automatic apply_setting(input logic pal, input logic boxed, input int mode,
                               input int vs, input int hs);
    logic same;
    same = (palmode_i == pal) && (palmode_boxed_i == boxed) &&
           (video_mode_i == vmode_t'(mode)) && (vscale_factor_i == scale_t'(vs)) &&
           (hscale_factor_i == scale_t'(hs));
    set_expected(pal, boxed, mode, vs, hs);
    drive_inputs(pal, boxed, mode, vs, hs);
    if (!same) begin
      wait_update();
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    @(negedge SYS_CLK);
    test_cnt++;
    if (err_cnt != err_before) begin
      test_fail_cnt++;
      $display("test %0d %s: failed with %0d errors", test_cnt, name, err_cnt - err_before);
    end else begin
      $display("test %0d %s: ok", test_cnt, name);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    int errs0;
    int mode;
    int vs;
    int hs;
    reset_i         = 1'b1;
    palmode_i       = 1'b0;
    palmode_boxed_i = 1'b0;
    video_mode_i    = '0;
    vscale_factor_i = '0;
    hscale_factor_i = '0;
    set_expected(1'b0, 1'b0, 0, 0, 0);
    repeat (3) @(posedge SYS_CLK);
    @(negedge SYS_CLK);
    reset_i = 1'b0;

    errs0 = err_cnt;  // one run must follow reset on its own.
    wait_update();
    check_quiet();
    finish_test("reset default", errs0);

    errs0 = err_cnt;
    apply_setting(1'b0, 1'b0, 3, 0, 0);  // clamps needed to the full source.
    apply_setting(1'b0, 1'b0, 0, 31, 0);
    for (int i = 0; i < 20; i++) begin
      mode = $random(seed) & 3;
      vs   = $random(seed) & 31;
      apply_setting(1'b0, 1'b0, mode, vs, 0);
    end
    finish_test("ntsc vertical", errs0);

    errs0 = err_cnt;
    apply_setting(1'b1, 1'b1, 0, 0, 0);
    apply_setting(1'b1, 1'b0, 0, 0, 0);
    for (int i = 0; i < 8; i++) begin
      mode = $random(seed) & 3;
      vs   = $random(seed) & 31;
      apply_setting(1'b1, i[0], mode, vs, 0);
    end
    finish_test("pal and boxed pal", errs0);

    errs0 = err_cnt;
    for (int i = 0; i < 12; i++) begin
      hs = $random(seed) & 31;
      apply_setting(1'b0, 1'b0, i % 4, 8, hs);
    end
    finish_test("horizontal modes", errs0);

    errs0 = err_cnt;
    set_expected(1'b1, 1'b0, 2, 12, 5);
    drive_inputs(1'b1, 1'b0, 2, 12, 5);
    repeat (6) @(negedge SYS_CLK);
    drive_inputs(1'b1, 1'b1, 1, 20, 27);  // dividers are busy here.
    wait_update();
    set_expected(1'b1, 1'b1, 1, 20, 27);
    wait_update();
    check_quiet();
    finish_test("change mid calculation", errs0);

    $display("tests %0d, failed %0d, errors %0d", test_cnt, test_fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
